// ==== logic/axi_pkg.sv ====
// single-ID AXI4 subset with INCR bursts of full-width beats only and no ID, LOCK, QOS, REGION, CACHE or PROT
package axi_pkg;

    localparam int addr_w    = 32;
    localparam int data_w    = 64;
    localparam int strb_w    = data_w / 8;          // one strobe per byte lane
    localparam int lane_bits = $clog2(strb_w);      // address bits inside one beat
    localparam int len_w     = 8;

    localparam logic [2:0] size_code  = 3'(lane_bits);   // every beat uses the full bus
    localparam logic [1:0] burst_incr = 2'b01;

    typedef enum logic [1:0] {
        okay   = 2'b00,
        exokay = 2'b01,
        slverr = 2'b10,
        decerr = 2'b11
    } resp_t;

    // shared by the AW and AR channels
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [len_w-1:0]  len;     // beats minus one
    } aw_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
        logic              last;
    } w_t;

    typedef struct packed {
        resp_t resp;
    } b_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        resp_t             resp;
        logic              last;
    } r_t;

endpackage

// ==== logic/burst_pkg.sv ====
// user commands span at most one 4 KiB page boundary since 256 beats of 8 bytes is half a page
package burst_pkg;

    localparam int page_bytes = 4096;
    localparam int page_bits  = $clog2(page_bytes);

    // one user request
    typedef struct packed {
        logic [axi_pkg::addr_w-1:0] addr;   // must be beat aligned
        logic [axi_pkg::len_w-1:0]  len;    // beats minus one
    } cmd_t;

    // burst currently offered by a planner
    typedef struct packed {
        logic [axi_pkg::addr_w-1:0] addr;
        logic [axi_pkg::len_w-1:0]  len;
        logic                       last;   // no further burst follows for this command
    } burst_t;

    typedef struct packed {
        logic misaligned;
        logic short_data;   // FIFO held fewer beats than requested
    } wr_err_t;

endpackage

// ==== logic/burst_planner.sv ====
// holds one command and offers at most two page-safe bursts; address math assumes a beat-aligned start
`timescale 1ns/1ps

module burst_planner
(
    input  logic                aclk,
    input  logic                aresetn,
    input  logic                load,
    input  burst_pkg::cmd_t     cmd,
    input  logic                next,
    output burst_pkg::burst_t   burst,
    output logic                misaligned
);

    typedef logic [burst_pkg::page_bits-axi_pkg::lane_bits:0] beats_t;

    burst_pkg::cmd_t                cmd_q;
    logic                           on_rem;         // remainder burst is on offer
    logic [burst_pkg::page_bits:0]  bytes_left;     // 8 up to a full page
    beats_t                         beats_left;
    logic [axi_pkg::len_w:0]        beats_total;
    beats_t                         first_m1;
    beats_t                         rem_m1;
    logic                           split;
    logic [axi_pkg::len_w-1:0]      first_len;
    logic [axi_pkg::len_w-1:0]      rem_len;
    logic [axi_pkg::addr_w-1:0]     rem_addr;

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
            on_rem <= 1'b0;
        else if (load)
            on_rem <= 1'b0;
        else if (next)
            on_rem <= 1'b1;
    end

    always_ff @(posedge aclk)
    begin
        if (load)
            cmd_q <= cmd;
    end

    // distance to the next page edge, in bytes and then in beats
    assign bytes_left  = (burst_pkg::page_bits + 1)'(burst_pkg::page_bytes)
                       - {1'b0, cmd_q.addr[burst_pkg::page_bits-1:0]};
    assign beats_left  = bytes_left[burst_pkg::page_bits:axi_pkg::lane_bits];
    assign beats_total = {1'b0, cmd_q.len} + 1'b1;

    assign split    = beats_t'(beats_total) > beats_left;
    assign first_m1 = beats_left - 1'b1;
    assign rem_m1   = beats_t'(beats_total) - beats_left - 1'b1;   // valid only when split

    assign first_len = split ? first_m1[axi_pkg::len_w-1:0] : cmd_q.len;
    assign rem_len   = rem_m1[axi_pkg::len_w-1:0];

    // second burst starts right on the page edge
    assign rem_addr = {cmd_q.addr[axi_pkg::addr_w-1:burst_pkg::page_bits] + 1'b1,
                       {burst_pkg::page_bits{1'b0}}};

    always_comb
    begin
        if (on_rem)
        begin
            burst.addr = rem_addr;
            burst.len  = rem_len;
            burst.last = 1'b1;
        end
        else
        begin
            burst.addr = cmd_q.addr;
            burst.len  = first_len;
            burst.last = !split;
        end
    end

    assign misaligned = |cmd_q.addr[axi_pkg::lane_bits-1:0];

endmodule

// ==== logic/write_engine.sv ====
// safe-mode writer that starts only when the FIFO already holds every beat, one burst in flight
`timescale 1ns/1ps

module write_engine
(
    input  logic                    aclk,
    input  logic                    aresetn,
    input  logic                    start,
    input  burst_pkg::cmd_t         cmd,
    output logic                    free,
    output burst_pkg::wr_err_t      error,
    output axi_pkg::resp_t          status,
    input  logic [axi_pkg::len_w:0] fifo_cnt,
    input  axi_pkg::w_t             fifo_data,
    output logic                    pop,
    output axi_pkg::aw_t            aw,
    output logic                    aw_valid,
    input  logic                    aw_ready,
    output axi_pkg::w_t             w,
    output logic                    w_valid,
    input  logic                    w_ready,
    input  axi_pkg::b_t             b,
    input  logic                    b_valid,
    output logic                    b_ready,
    output logic                    plan_load,
    output burst_pkg::cmd_t         plan_cmd,
    output logic                    plan_next,
    input  burst_pkg::burst_t       burst,
    input  logic                    misaligned
);

    typedef enum logic [4:0] {
        st_idle    = 5'b00001,
        st_check   = 5'b00010,
        st_address = 5'b00100,
        st_data    = 5'b01000,
        st_resp    = 5'b10000
    } state_t;

    state_t                     state;
    state_t                     state_nx;
    logic [axi_pkg::len_w-1:0]  len_q;      // whole command, beats minus one
    logic [axi_pkg::len_w-1:0]  beat_cnt;   // beats sent in the current burst
    logic                       accept;
    logic                       short_data;
    logic                       w_fire;
    logic                       b_fire;

    assign free       = (state == st_idle);
    assign accept     = start && free;
    assign w_fire     = w_valid && w_ready;
    assign b_fire     = b_valid && b_ready;
    assign short_data = fifo_cnt < ({1'b0, len_q} + 1'b1);

    always_comb
    begin
        state_nx = state;
        case (state)
            st_idle:    if (accept) state_nx = st_check;
            st_check:   state_nx = (misaligned || short_data) ? st_idle : st_address;
            st_address: if (aw_ready) state_nx = st_data;
            st_data:    if (w_fire && w.last) state_nx = st_resp;
            st_resp:    if (b_fire) state_nx = burst.last ? st_idle : st_address;
            default:    state_nx = st_idle;
        endcase
    end

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
            state <= st_idle;
        else
            state <= state_nx;
    end

    always_ff @(posedge aclk)
    begin
        if (accept)
            len_q <= cmd.len;
    end

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
            beat_cnt <= '0;
        else if (state == st_address)
            beat_cnt <= '0;                 // restart for each burst
        else if (w_fire)
            beat_cnt <= beat_cnt + 1'b1;
    end

    // error and status hold until the next command is taken
    always_ff @(posedge aclk)
    begin
        if (!aresetn || accept)
        begin
            error  <= '0;
            status <= axi_pkg::okay;
        end
        else
        begin
            if (state == st_check)
            begin
                error.misaligned <= misaligned;
                error.short_data <= short_data;
            end
            if (b_fire)
                status <= b.resp;           // last burst wins
        end
    end

    assign plan_load = accept;
    assign plan_cmd  = cmd;
    assign plan_next = b_fire;

    assign aw       = axi_pkg::aw_t'{addr: burst.addr, len: burst.len};
    assign aw_valid = (state == st_address);
    assign w_valid  = (state == st_data);  // data was counted before the address went out
    assign b_ready  = (state == st_resp);
    assign pop      = w_fire;

    always_comb
    begin
        w      = fifo_data;
        w.last = (beat_cnt == burst.len);
    end

endmodule

// ==== logic/read_engine.sv ====
// reader with one burst in flight; a full user FIFO stalls RREADY and a misaligned start aborts
`timescale 1ns/1ps

module read_engine
(
    input  logic                        aclk,
    input  logic                        aresetn,
    input  logic                        start,
    input  burst_pkg::cmd_t             cmd,
    output logic                        free,
    output logic                        error,
    output axi_pkg::resp_t              status,
    input  logic                        fifo_full,
    output logic                        push,
    output logic [axi_pkg::data_w-1:0]  data,
    output axi_pkg::aw_t                ar,
    output logic                        ar_valid,
    input  logic                        ar_ready,
    input  axi_pkg::r_t                 r,
    input  logic                        r_valid,
    output logic                        r_ready,
    output logic                        plan_load,
    output burst_pkg::cmd_t             plan_cmd,
    output logic                        plan_next,
    input  burst_pkg::burst_t           burst,
    input  logic                        misaligned
);

    typedef enum logic [3:0] {
        st_idle    = 4'b0001,
        st_check   = 4'b0010,
        st_address = 4'b0100,
        st_resp    = 4'b1000
    } state_t;

    state_t state;
    state_t state_nx;
    logic   accept;
    logic   r_fire;

    assign free   = (state == st_idle);
    assign accept = start && free;
    assign r_fire = r_valid && r_ready;

    always_comb
    begin
        state_nx = state;
        case (state)
            st_idle:    if (accept) state_nx = st_check;
            st_check:   state_nx = misaligned ? st_idle : st_address;
            st_address: if (ar_ready) state_nx = st_resp;
            st_resp:    if (r_fire && r.last) state_nx = burst.last ? st_idle : st_address;
            default:    state_nx = st_idle;
        endcase
    end

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
            state <= st_idle;
        else
            state <= state_nx;
    end

    always_ff @(posedge aclk)
    begin
        if (!aresetn || accept)
        begin
            error  <= 1'b0;
            status <= axi_pkg::okay;
        end
        else
        begin
            if (state == st_check)
                error <= misaligned;
            if (r_fire && (r.resp > status))
                status <= r.resp;           // keep the worst code seen
        end
    end

    assign plan_load = accept;
    assign plan_cmd  = cmd;
    assign plan_next = r_fire && r.last;

    assign ar       = axi_pkg::aw_t'{addr: burst.addr, len: burst.len};
    assign ar_valid = (state == st_address);
    assign r_ready  = (state == st_resp) && !fifo_full;
    assign push     = r_fire;
    assign data     = r.data;

endmodule

// ==== logic/axi_burst_master.sv ====
// single-ID AXI4 master with full-width INCR bursts; the write FIFO must be first-word-fall-through
`timescale 1ns/1ps

module axi_burst_master
(
    input  logic                        aclk,
    input  logic                        aresetn,
    // write command and status
    input  logic                        w_start,
    input  burst_pkg::cmd_t             w_cmd,
    output logic                        w_free,
    output burst_pkg::wr_err_t          w_error,
    output axi_pkg::resp_t              w_status,
    // write FIFO
    input  logic [axi_pkg::data_w-1:0]  w_data,
    input  logic [axi_pkg::strb_w-1:0]  w_strb,
    input  logic [axi_pkg::len_w:0]     w_fifo_cnt,
    input  logic                        w_fifo_empty,
    output logic                        w_pop,
    // read command and status
    input  logic                        r_start,
    input  burst_pkg::cmd_t             r_cmd,
    output logic                        r_free,
    output logic                        r_error,
    output axi_pkg::resp_t              r_status,
    // read FIFO
    output logic [axi_pkg::data_w-1:0]  r_data,
    input  logic                        r_fifo_full,
    output logic                        r_push,
    // AXI write channels
    output axi_pkg::aw_t                m_axi_aw,
    output logic                        m_axi_awvalid,
    input  logic                        m_axi_awready,
    output logic [2:0]                  m_axi_awsize,
    output logic [1:0]                  m_axi_awburst,
    output axi_pkg::w_t                 m_axi_w,
    output logic                        m_axi_wvalid,
    input  logic                        m_axi_wready,
    input  axi_pkg::b_t                 m_axi_b,
    input  logic                        m_axi_bvalid,
    output logic                        m_axi_bready,
    // AXI read channels
    output axi_pkg::aw_t                m_axi_ar,
    output logic                        m_axi_arvalid,
    input  logic                        m_axi_arready,
    output logic [2:0]                  m_axi_arsize,
    output logic [1:0]                  m_axi_arburst,
    input  axi_pkg::r_t                 m_axi_r,
    input  logic                        m_axi_rvalid,
    output logic                        m_axi_rready
);

    axi_pkg::w_t                w_fifo_word;
    logic [axi_pkg::len_w:0]    w_level;
    logic                       wr_load;
    burst_pkg::cmd_t            wr_cmd;
    logic                       wr_next;
    burst_pkg::burst_t          wr_burst;
    logic                       wr_misaligned;
    logic                       rd_load;
    burst_pkg::cmd_t            rd_cmd;
    logic                       rd_next;
    burst_pkg::burst_t          rd_burst;
    logic                       rd_misaligned;

    // last is filled in by the engine
    assign w_fifo_word = axi_pkg::w_t'{data: w_data, strb: w_strb, last: 1'b0};
    assign w_level     = w_fifo_empty ? '0 : w_fifo_cnt;   // empty FIFO counts as no beats

    assign m_axi_awsize  = axi_pkg::size_code;
    assign m_axi_awburst = axi_pkg::burst_incr;
    assign m_axi_arsize  = axi_pkg::size_code;
    assign m_axi_arburst = axi_pkg::burst_incr;

    burst_planner u_wr_plan
    (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .load       (wr_load),
        .cmd        (wr_cmd),
        .next       (wr_next),
        .burst      (wr_burst),
        .misaligned (wr_misaligned)
    );

    burst_planner u_rd_plan
    (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .load       (rd_load),
        .cmd        (rd_cmd),
        .next       (rd_next),
        .burst      (rd_burst),
        .misaligned (rd_misaligned)
    );

    write_engine u_wr
    (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .start      (w_start),
        .cmd        (w_cmd),
        .free       (w_free),
        .error      (w_error),
        .status     (w_status),
        .fifo_cnt   (w_level),
        .fifo_data  (w_fifo_word),
        .pop        (w_pop),
        .aw         (m_axi_aw),
        .aw_valid   (m_axi_awvalid),
        .aw_ready   (m_axi_awready),
        .w          (m_axi_w),
        .w_valid    (m_axi_wvalid),
        .w_ready    (m_axi_wready),
        .b          (m_axi_b),
        .b_valid    (m_axi_bvalid),
        .b_ready    (m_axi_bready),
        .plan_load  (wr_load),
        .plan_cmd   (wr_cmd),
        .plan_next  (wr_next),
        .burst      (wr_burst),
        .misaligned (wr_misaligned)
    );

    read_engine u_rd
    (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .start      (r_start),
        .cmd        (r_cmd),
        .free       (r_free),
        .error      (r_error),
        .status     (r_status),
        .fifo_full  (r_fifo_full),
        .push       (r_push),
        .data       (r_data),
        .ar         (m_axi_ar),
        .ar_valid   (m_axi_arvalid),
        .ar_ready   (m_axi_arready),
        .r          (m_axi_r),
        .r_valid    (m_axi_rvalid),
        .r_ready    (m_axi_rready),
        .plan_load  (rd_load),
        .plan_cmd   (rd_cmd),
        .plan_next  (rd_next),
        .burst      (rd_burst),
        .misaligned (rd_misaligned)
    );

endmodule

// ==== bench/axi_mem_slave.sv ====
// AXI slave model for one burst at a time per direction; full-width beats only, unwritten words read a fill pattern
`timescale 1ns/1ps

module axi_mem_slave
(
    input  logic            aclk,
    input  logic            aresetn,
    input  axi_pkg::resp_t  bresp,      // answer given to every write burst
    input  axi_pkg::aw_t    aw,
    input  logic            awvalid,
    output logic            awready,
    input  axi_pkg::w_t     w,
    input  logic            wvalid,
    output logic            wready,
    output axi_pkg::b_t     b,
    output logic            bvalid,
    input  logic            bready,
    input  axi_pkg::aw_t    ar,
    input  logic            arvalid,
    output logic            arready,
    output axi_pkg::r_t     r,
    output logic            rvalid,
    input  logic            rready
);

    logic [axi_pkg::data_w-1:0] mem [logic [31:0]];    // keyed by word index
    axi_pkg::aw_t               aw_log [$];
    axi_pkg::aw_t               ar_log [$];

    logic                       w_busy;
    logic [31:0]                w_addr;
    logic                       r_busy;
    logic [31:0]                r_addr;
    logic [axi_pkg::len_w-1:0]  r_left;
    logic [axi_pkg::data_w-1:0] word;
    logic [31:0]                idx;

    function automatic logic [axi_pkg::data_w-1:0] fill_word(input logic [31:0] i);
        return {~i, i ^ 32'h5a5a_a5a5};
    endfunction

    function automatic logic [axi_pkg::data_w-1:0] peek(input logic [31:0] i);
        return mem.exists(i) ? mem[i] : fill_word(i);
    endfunction

    initial
    begin
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        b       = '0;
        arready = 1'b0;
        rvalid  = 1'b0;
        r       = '0;
    end

    // write side: AW, then beats with random wready, then B
    always @(posedge aclk)
    begin
        if (!aresetn)
        begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            w_busy  <= 1'b0;
        end
        else
        begin
            if (!w_busy)
            begin
                if (awvalid && awready)
                begin
                    aw_log.push_back(aw);
                    w_addr  <= aw.addr;
                    w_busy  <= 1'b1;
                    awready <= 1'b0;
                end
                else
                    awready <= ($urandom % 4) != 0;
            end
            if (w_busy && !bvalid)
            begin
                if (wvalid && wready)
                begin
                    idx  = w_addr >> axi_pkg::lane_bits;
                    word = peek(idx);
                    for (int k = 0; k < axi_pkg::strb_w; k++)
                        if (w.strb[k])
                            word[8*k +: 8] = w.data[8*k +: 8];
                    mem[idx] = word;
                    w_addr <= w_addr + 32'(axi_pkg::strb_w);
                    if (w.last)
                    begin
                        bvalid <= 1'b1;
                        b.resp <= bresp;
                        wready <= 1'b0;
                    end
                    else
                        wready <= ($urandom % 3) != 0;
                end
                else
                    wready <= ($urandom % 3) != 0;
            end
            if (bvalid && bready)
            begin
                bvalid <= 1'b0;
                w_busy <= 1'b0;
            end
        end
    end

    // read side: beats come out with random gaps
    always @(posedge aclk)
    begin
        if (!aresetn)
        begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            r_busy  <= 1'b0;
        end
        else if (!r_busy)
        begin
            if (arvalid && arready)
            begin
                ar_log.push_back(ar);
                r_addr  <= ar.addr;
                r_left  <= ar.len;
                r_busy  <= 1'b1;
                arready <= 1'b0;
            end
            else
                arready <= ($urandom % 4) != 0;
        end
        else if (!rvalid || rready)
        begin
            if (rvalid && r.last)
            begin
                rvalid <= 1'b0;     // burst done
                r_busy <= 1'b0;
            end
            else if (($urandom % 4) != 0)
            begin
                rvalid <= 1'b1;
                r      <= '{data: peek(r_addr >> axi_pkg::lane_bits),
                            resp: axi_pkg::okay, last: (r_left == '0)};
                r_addr <= r_addr + 32'(axi_pkg::strb_w);
                r_left <= r_left - 1'b1;
            end
            else
                rvalid <= 1'b0;
        end
    end

endmodule

// ==== bench/tb_axi_burst_master.sv ====
// testbench for the burst master; entries run in order and later reads expect words from earlier writes
`timescale 1ns/1ps

module tb_axi_burst_master;

    typedef struct packed {
        logic                  is_read;
        burst_pkg::cmd_t       cmd;
        logic [8:0]            preload;     // words put in the write FIFO
        axi_pkg::resp_t        bresp;
        burst_pkg::wr_err_t    exp_err;     // misaligned bit doubles as r_error for reads
    } entry_t;

    localparam int n_entries = 8;
    localparam logic [2:0] exp_size  = 3'd3;    // 8-byte beats on a 64-bit bus
    localparam logic [1:0] exp_burst = 2'b01;   // INCR

    logic aclk;
    logic aresetn;
    logic w_start;
    burst_pkg::cmd_t w_cmd;
    logic w_free;
    burst_pkg::wr_err_t w_error;
    axi_pkg::resp_t w_status;
    logic [axi_pkg::data_w-1:0] w_data;
    logic [axi_pkg::strb_w-1:0] w_strb;
    logic [axi_pkg::len_w:0] w_fifo_cnt;
    logic w_fifo_empty;
    logic w_pop;
    logic r_start;
    burst_pkg::cmd_t r_cmd;
    logic r_free;
    logic r_error;
    axi_pkg::resp_t r_status;
    logic [axi_pkg::data_w-1:0] r_data;
    logic r_fifo_full;
    logic r_push;
    axi_pkg::aw_t aw;
    axi_pkg::aw_t ar;
    axi_pkg::w_t w;
    axi_pkg::b_t b;
    axi_pkg::r_t r;
    logic awvalid;
    logic awready;
    logic wvalid;
    logic wready;
    logic bvalid;
    logic bready;
    logic arvalid;
    logic arready;
    logic rvalid;
    logic rready;
    logic [2:0] awsize;
    logic [2:0] arsize;
    logic [1:0] awburst;
    logic [1:0] arburst;
    axi_pkg::resp_t slave_bresp;

    entry_t tests [n_entries];
    logic [axi_pkg::data_w-1:0] wq [$];           // write FIFO contents
    logic [axi_pkg::data_w-1:0] rq [$];           // words pushed to the read FIFO
    logic [axi_pkg::data_w-1:0] model_mem [int];
    int err_cnt = 0;

    axi_burst_master uut
    (
        .aclk(aclk), .aresetn(aresetn),
        .w_start(w_start), .w_cmd(w_cmd), .w_free(w_free), .w_error(w_error),
        .w_status(w_status), .w_data(w_data), .w_strb(w_strb), .w_fifo_cnt(w_fifo_cnt),
        .w_fifo_empty(w_fifo_empty), .w_pop(w_pop),
        .r_start(r_start), .r_cmd(r_cmd), .r_free(r_free), .r_error(r_error),
        .r_status(r_status), .r_data(r_data), .r_fifo_full(r_fifo_full), .r_push(r_push),
        .m_axi_aw(aw), .m_axi_awvalid(awvalid), .m_axi_awready(awready),
        .m_axi_awsize(awsize), .m_axi_awburst(awburst),
        .m_axi_w(w), .m_axi_wvalid(wvalid), .m_axi_wready(wready),
        .m_axi_b(b), .m_axi_bvalid(bvalid), .m_axi_bready(bready),
        .m_axi_ar(ar), .m_axi_arvalid(arvalid), .m_axi_arready(arready),
        .m_axi_arsize(arsize), .m_axi_arburst(arburst),
        .m_axi_r(r), .m_axi_rvalid(rvalid), .m_axi_rready(rready)
    );

    axi_mem_slave u_slave
    (
        .aclk(aclk), .aresetn(aresetn), .bresp(slave_bresp),
        .aw(aw), .awvalid(awvalid), .awready(awready),
        .w(w), .wvalid(wvalid), .wready(wready),
        .b(b), .bvalid(bvalid), .bready(bready),
        .ar(ar), .arvalid(arvalid), .arready(arready),
        .r(r), .rvalid(rvalid), .rready(rready)
    );

    initial
    begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    task automatic fail_now(input string what);
        err_cnt++;
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_resp(input string name, input axi_pkg::resp_t got,
                              input axi_pkg::resp_t exp);
        if (got !== exp)
            fail_now($sformatf("ERR %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_wr_err(input string name, input burst_pkg::wr_err_t got,
                                input burst_pkg::wr_err_t exp);
        if (got !== exp)
            fail_now($sformatf("ERR %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_burst(input string name, input axi_pkg::aw_t got,
                               input axi_pkg::aw_t exp);
        if (got !== exp)
            fail_now($sformatf("ERR %s got addr %h len %h expected addr %h len %h",
                               name, got.addr, got.len, exp.addr, exp.len));
    endtask

    task automatic check_word(input string name, input logic [axi_pkg::data_w-1:0] got,
                              input logic [axi_pkg::data_w-1:0] exp);
        if (got !== exp)
            fail_now($sformatf("ERR %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_now($sformatf("ERR %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_size(input string name, input logic [2:0] got,
                              input logic [2:0] exp);
        if (got !== exp)
            fail_now($sformatf("ERR %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_burst_type(input string name, input logic [1:0] got,
                                    input logic [1:0] exp);
        if (got !== exp)
            fail_now($sformatf("ERR %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
            fail_now($sformatf("ERR %s got %h expected %h", name, got, exp));
    endtask

    // FWFT write FIFO model
    always @(posedge aclk)
    begin
        if (w_pop && wq.size() > 0)
            wq.delete(0);
        w_data       <= (wq.size() > 0) ? wq[0] : '0;
        w_fifo_cnt   <= 9'(wq.size());
        w_fifo_empty <= (wq.size() == 0);
        r_fifo_full  <= ($urandom % 3) == 0;        // random back-pressure
    end

    always @(posedge aclk)
    begin
        if (r_push && r_fifo_full)
            fail_now("r_push fired while the read FIFO was full");
        if (r_push)
            rq.push_back(r_data);
    end

    // fixed codes are looked at whenever an address is on offer
    always @(posedge aclk)
    begin
        if (awvalid)
        begin
            check_size("m_axi_awsize", awsize, exp_size);
            check_burst_type("m_axi_awburst", awburst, exp_burst);
        end
        if (arvalid)
        begin
            check_size("m_axi_arsize", arsize, exp_size);
            check_burst_type("m_axi_arburst", arburst, exp_burst);
        end
    end

    task automatic run_entry(input entry_t e);
        axi_pkg::aw_t exp_b [2];
        int beats;
        int to_page;
        int n_exp;
        int base;
        logic [axi_pkg::data_w-1:0] words [$];
        beats   = int'(e.cmd.len) + 1;
        to_page = (burst_pkg::page_bytes - int'(e.cmd.addr % burst_pkg::page_bytes)) / 8;
        base    = int'(e.cmd.addr >> 3);
        exp_b[0] = '{addr: e.cmd.addr, len: e.cmd.len};
        n_exp    = 1;
        if (beats > to_page)
        begin
            exp_b[0].len = 8'(to_page - 1);
            exp_b[1] = '{addr: (e.cmd.addr & ~32'(burst_pkg::page_bytes - 1))
                              + 32'(burst_pkg::page_bytes),
                         len: 8'(beats - to_page - 1)};
            n_exp = 2;
        end
        if (e.exp_err != 2'b00)
            n_exp = 0;                          // refused commands put nothing on the bus
        if (!e.is_read)
        begin
            while (!w_free)
                @(posedge aclk);
            wq.delete();
            u_slave.aw_log.delete();
            slave_bresp <= e.bresp;
            for (int k = 0; k < int'(e.preload); k++)
            begin
                words.push_back({$urandom, $urandom});
                wq.push_back(words[k]);
            end
            repeat (2) @(posedge aclk);        // FIFO level settles
            w_cmd   <= e.cmd;
            w_start <= 1'b1;
            @(posedge aclk);
            w_start <= 1'b0;
            @(posedge aclk);
            while (!w_free)
                @(posedge aclk);
            check_wr_err("w_error", w_error, e.exp_err);
            check_resp("w_status", w_status, (e.exp_err != 2'b00) ? axi_pkg::okay : e.bresp);
            check_count("aw burst count", u_slave.aw_log.size(), n_exp);
            for (int i = 0; i < n_exp; i++)
                check_burst("m_axi_aw", u_slave.aw_log[i], exp_b[i]);
            for (int k = 0; k < beats && n_exp > 0; k++)
            begin
                model_mem[base + k] = words[k];
                check_word("slave mem", u_slave.peek(32'(base + k)), words[k]);
            end
        end
        else
        begin
            while (!r_free)
                @(posedge aclk);
            rq.delete();
            u_slave.ar_log.delete();
            r_cmd   <= e.cmd;
            r_start <= 1'b1;
            @(posedge aclk);
            r_start <= 1'b0;
            @(posedge aclk);
            while (!r_free)
                @(posedge aclk);
            check_flag("r_error", r_error, e.exp_err.misaligned);
            check_resp("r_status", r_status, axi_pkg::okay);
            check_count("ar burst count", u_slave.ar_log.size(), n_exp);
            for (int i = 0; i < n_exp; i++)
                check_burst("m_axi_ar", u_slave.ar_log[i], exp_b[i]);
            check_count("read word count", rq.size(), (n_exp > 0) ? beats : 0);
            for (int k = 0; k < rq.size(); k++)
                check_word("r_data", rq[k], model_mem[base + k]);
        end
    endtask

    initial
    begin
        repeat (n_entries * 2000 + 10) @(posedge aclk);
        $display("run hung: the last command never finished");
        $display("tests failed");
        $fatal(1);
    end

    initial
    begin
        void'($urandom(32'h8aef_28b7));
        // dir, {addr, len}, preload, bresp, expected error
        tests[0] = '{1'b0, {32'h0000_1000, 8'd15}, 9'd16, axi_pkg::okay, 2'b00};
        tests[1] = '{1'b0, {32'h0000_1fc0, 8'd31}, 9'd32, axi_pkg::okay, 2'b00};
        tests[2] = '{1'b0, {32'h0000_3004, 8'd3}, 9'd4, axi_pkg::okay, 2'b10};
        tests[3] = '{1'b0, {32'h0000_4000, 8'd7}, 9'd5, axi_pkg::okay, 2'b01};
        tests[4] = '{1'b1, {32'h0000_1fc0, 8'd31}, 9'd0, axi_pkg::okay, 2'b00};
        tests[5] = '{1'b1, {32'h0000_1003, 8'd1}, 9'd0, axi_pkg::okay, 2'b10};
        tests[6] = '{1'b0, {32'h0000_5ff0, 8'd3}, 9'd4, axi_pkg::slverr, 2'b00};
        tests[7] = '{1'b1, {32'h0000_1000, 8'd15}, 9'd0, axi_pkg::okay, 2'b00};
        aresetn      = 1'b0;
        w_start      = 1'b0;
        w_cmd        = '0;
        w_strb       = '1;
        w_data       = '0;
        w_fifo_cnt   = '0;
        w_fifo_empty = 1'b1;
        r_start      = 1'b0;
        r_cmd        = '0;
        r_fifo_full  = 1'b0;
        slave_bresp  = axi_pkg::okay;
        repeat (10) @(posedge aclk);
        aresetn <= 1'b1;
        @(posedge aclk);
        if (!w_free || !r_free)
            fail_now("free outputs were not high after reset");
        if (awvalid || wvalid || bready || arvalid || rready || w_pop || r_push)
            fail_now("a valid, ready, pop or push output was high after reset");
        for (int i = 0; i < n_entries; i++)
            run_entry(tests[i]);
        if (err_cnt == 0)
        begin
            $display("all tests passed");
            $finish;
        end
        else
        begin
            $display("tests failed");
            $fatal(1);
        end
    end

endmodule

// ==== compile.f ====
logic/axi_pkg.sv
logic/burst_pkg.sv
logic/burst_planner.sv
logic/write_engine.sv
logic/read_engine.sv
logic/axi_burst_master.sv
bench/axi_mem_slave.sv
bench/tb_axi_burst_master.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_axi_burst_master
FILELIST = compile.f

SRCS = $(shell grep -v '^+' $(FILELIST))
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf obj_dir
